/* include/dnc_params.svh */
// DNC read content weighting parameters
// Element width and the vector and row limits of one run

`ifndef DNC_PARAMS_SVH
`define DNC_PARAMS_SVH

//////////////////////////////
// Element format
//////////////////////////////

// Bits per key or memory element, signed
`define DNC_ELEM_WIDTH 8

//////////////////////////////
// Run limits
//////////////////////////////

// Longest key or memory row, also the key buffer depth
`define DNC_MAX_W 16

// Most memory rows in one run
`define DNC_MAX_N 64

`endif

/* logic/dnc_elem_pkg.sv */
// DNC arithmetic types
// Element, key strength, accumulator and score words of the content datapath

`include "dnc_params.svh"

package dnc_elem_pkg;

  //////////////////////////////
  // Datapath words
  //////////////////////////////

  // Signed key or memory element
  typedef logic signed [`DNC_ELEM_WIDTH-1:0] elem_t;

  // Key strength beta, unsigned
  typedef logic [7:0] beta_t;

  // Dot product and energy sums
  // 16 products of 8-bit elements stay well inside 24 bits
  typedef logic signed [23:0] acc_t;

  // Beta-scaled content score, exact for all legal inputs
  typedef logic signed [31:0] score_t;

endpackage

/* logic/dnc_ctrl_pkg.sv */
// DNC control types
// Element and row counters plus the combiner state encoding

`include "dnc_params.svh"

package dnc_ctrl_pkg;

  //////////////////////////////
  // Counters
  //////////////////////////////

  // Element index and vector length, wide enough to hold the maximum itself
  typedef logic [$clog2(`DNC_MAX_W + 1)-1:0] elem_idx_t;

  // Row index, row count and best row
  typedef logic [$clog2(`DNC_MAX_N + 1)-1:0] row_idx_t;

  //////////////////////////////
  // Combiner FSM
  //////////////////////////////

  typedef enum logic {
    IDLE,
    RUN
  } comb_state_t;

endpackage

/* logic/dnc_key_similarity.sv */
// DNC key similarity unit
// Buffers the key, then accumulates k . M[j] over each streamed memory row
// and flags the end of every row with a registered pulse

`timescale 1ns/1ns

`include "dnc_params.svh"

module dnc_key_similarity (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  dnc_ctrl_pkg::elem_idx_t size_w,
  input  logic                   k_in_enable,
  input  dnc_elem_pkg::elem_t    k_in,
  input  logic                   m_in_j_enable,
  input  logic                   m_in_k_enable,
  input  dnc_elem_pkg::elem_t    m_in,
  output dnc_elem_pkg::acc_t     dot_acc,
  output logic                   row_done
);

  // Key buffer address bits
  localparam int KEY_AW = $clog2(`DNC_MAX_W);

  //////////////////////////////
  // Signals
  //////////////////////////////

  dnc_elem_pkg::elem_t     key_mem [`DNC_MAX_W];
  dnc_ctrl_pkg::elem_idx_t size_w_q;
  dnc_ctrl_pkg::elem_idx_t elem_cnt;
  logic [KEY_AW-1:0]       key_addr;
  logic                    elem_last;
  dnc_elem_pkg::acc_t      prod;

  // Counter never passes size_w_q - 1, so the low bits address the buffer
  assign key_addr  = elem_cnt[KEY_AW-1:0];
  assign elem_last = (elem_cnt == size_w_q - dnc_ctrl_pkg::elem_idx_t'(1));

  // Signed product, both sides widened first
  assign prod = dnc_elem_pkg::acc_t'(key_mem[key_addr]) * dnc_elem_pkg::acc_t'(m_in);

  //////////////////////////////
  // Element counter
  //////////////////////////////

  // Shared by key loading and row streaming
  // Start and row start both rewind it, last element wraps it
  always_ff @(posedge clk) begin
    if (rst) begin
      size_w_q <= dnc_ctrl_pkg::elem_idx_t'(`DNC_MAX_W);
      elem_cnt <= '0;
      row_done <= 1'b0;
    end else begin
      row_done <= 1'b0;
      if (start) begin
        size_w_q <= size_w;
        elem_cnt <= '0;
      end else if (m_in_j_enable) begin
        elem_cnt <= '0;
      end else if (k_in_enable || m_in_k_enable) begin
        elem_cnt <= elem_last ? '0 : elem_cnt + dnc_ctrl_pkg::elem_idx_t'(1);
        // Last memory element of the row
        row_done <= m_in_k_enable && elem_last;
      end
    end
  end

  //////////////////////////////
  // Key buffer and dot product
  //////////////////////////////

  // Key strobes write in arrival order
  always_ff @(posedge clk) begin
    if (k_in_enable && !start) begin
      key_mem[key_addr] <= k_in;
    end
  end

  // Cleared at row start, held after the last element for the combiner
  always_ff @(posedge clk) begin
    if (m_in_j_enable) begin
      dot_acc <= '0;
    end else if (m_in_k_enable) begin
      dot_acc <= dot_acc + prod;
    end
  end

endmodule

/* logic/dnc_row_energy.sv */
// DNC row energy unit
// Accumulates the squared norm of each streamed memory row, in step with
// the dot product of the key similarity unit

`timescale 1ns/1ns

module dnc_row_energy (
  input  logic                clk,
  input  logic                rst,
  input  logic                m_in_j_enable,
  input  logic                m_in_k_enable,
  input  dnc_elem_pkg::elem_t m_in,
  output dnc_elem_pkg::acc_t  energy_acc
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  dnc_elem_pkg::acc_t sq;

  // Square of the incoming element, never negative
  assign sq = dnc_elem_pkg::acc_t'(m_in) * dnc_elem_pkg::acc_t'(m_in);

  //////////////////////////////
  // Energy sum
  //////////////////////////////

  // Held until the next row start so the combiner sees a stable value
  always_ff @(posedge clk) begin
    if (rst) begin
      energy_acc <= '0;
    end else if (m_in_j_enable) begin
      energy_acc <= '0;
    end else if (m_in_k_enable) begin
      energy_acc <= energy_acc + sq;
    end
  end

endmodule

/* logic/dnc_weight_combine.sv */
// DNC weight combiner
// Scales each row result by beta into a content score, counts rows,
// drives ready and keeps the index of the highest scoring row

`timescale 1ns/1ns

module dnc_weight_combine (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  dnc_ctrl_pkg::row_idx_t size_n,
  input  dnc_elem_pkg::beta_t   beta,
  input  dnc_elem_pkg::acc_t    dot_acc,
  input  dnc_elem_pkg::acc_t    energy_acc,
  input  logic                  row_done,
  output logic                  ready,
  output logic                  c_out_enable,
  output dnc_elem_pkg::score_t  c_out,
  output dnc_ctrl_pkg::row_idx_t best_index,
  output logic                  best_valid
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  dnc_ctrl_pkg::comb_state_t state;
  dnc_ctrl_pkg::row_idx_t    size_n_q;
  dnc_ctrl_pkg::row_idx_t    row_cnt;
  dnc_elem_pkg::beta_t       beta_q;
  dnc_elem_pkg::score_t      diff;
  dnc_elem_pkg::score_t      score;
  dnc_elem_pkg::score_t      best_score;
  logic                      row_last;
  logic                      take_best;

  // 2 k.M - |M|^2, exact in 32 bits
  assign diff = dnc_elem_pkg::score_t'(dot_acc) + dnc_elem_pkg::score_t'(dot_acc)
              - dnc_elem_pkg::score_t'(energy_acc);

  // Beta zero extends, so the product keeps the sign of diff
  assign score = dnc_elem_pkg::score_t'(beta_q) * diff;

  assign row_last = (row_cnt == size_n_q - dnc_ctrl_pkg::row_idx_t'(1));

  // First row always wins, later rows only on a strictly higher score
  assign take_best = (row_cnt == '0) || (score > best_score);

  assign ready = (state == dnc_ctrl_pkg::IDLE);

  //////////////////////////////
  // Row FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= dnc_ctrl_pkg::IDLE;
      size_n_q     <= '0;
      beta_q       <= '0;
      row_cnt      <= '0;
      best_index   <= '0;
      c_out_enable <= 1'b0;
      best_valid   <= 1'b0;
    end else begin
      c_out_enable <= 1'b0;
      best_valid   <= 1'b0;
      case (state)
        dnc_ctrl_pkg::IDLE: begin
          // Capture run setup, previous best index dropped here
          if (start) begin
            size_n_q   <= size_n;
            beta_q     <= beta;
            row_cnt    <= '0;
            best_index <= '0;
            state      <= dnc_ctrl_pkg::RUN;
          end
        end
        dnc_ctrl_pkg::RUN: begin
          if (row_done) begin
            c_out_enable <= 1'b1;
            row_cnt      <= row_cnt + dnc_ctrl_pkg::row_idx_t'(1);
            if (take_best) begin
              best_index <= row_cnt;
            end
            // Ready and best_valid rise with the last score
            if (row_last) begin
              best_valid <= 1'b1;
              state      <= dnc_ctrl_pkg::IDLE;
            end
          end
        end
        default: state <= dnc_ctrl_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Score registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (row_done && state == dnc_ctrl_pkg::RUN) begin
      c_out <= score;
      if (take_best) begin
        best_score <= score;
      end
    end
  end

endmodule

/* logic/dnc_read_content_weighting.sv */
// DNC read content weighting, top level
// Scores every streamed memory row against the key as
// beta * (2 k.M[j] - |M[j]|^2) and reports the best matching row

`timescale 1ns/1ns

module dnc_read_content_weighting (
  // Clock and reset
  input  logic                   clk,
  input  logic                   rst,

  // Control
  input  logic                   start,
  output logic                   ready,

  // Run setup, sampled on start
  input  dnc_ctrl_pkg::row_idx_t  size_n_in,
  input  dnc_ctrl_pkg::elem_idx_t size_w_in,
  input  dnc_elem_pkg::beta_t     beta_in,

  // Key stream, W strobes
  input  logic                   k_in_enable,
  input  dnc_elem_pkg::elem_t     k_in,

  // Memory stream, one row start then W strobes per row
  input  logic                   m_in_j_enable,
  input  logic                   m_in_k_enable,
  input  dnc_elem_pkg::elem_t     m_in,

  // Scores, one pulse per row
  output logic                   c_out_enable,
  output dnc_elem_pkg::score_t    c_out,

  // Best row, valid from best_valid until the next start
  output dnc_ctrl_pkg::row_idx_t  best_index,
  output logic                   best_valid
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  dnc_elem_pkg::acc_t dot_acc;
  dnc_elem_pkg::acc_t energy_acc;
  logic               row_done;

  //////////////////////////////
  // Units
  //////////////////////////////

  // Key buffer and dot product, owns the element counter
  dnc_key_similarity i_dnc_key_similarity (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .size_w        (size_w_in),
    .k_in_enable   (k_in_enable),
    .k_in          (k_in),
    .m_in_j_enable (m_in_j_enable),
    .m_in_k_enable (m_in_k_enable),
    .m_in          (m_in),
    .dot_acc       (dot_acc),
    .row_done      (row_done)
  );

  // Squared norm on the same memory strobes
  dnc_row_energy i_dnc_row_energy (
    .clk           (clk),
    .rst           (rst),
    .m_in_j_enable (m_in_j_enable),
    .m_in_k_enable (m_in_k_enable),
    .m_in          (m_in),
    .energy_acc    (energy_acc)
  );

  // Scaling, row count and best row
  dnc_weight_combine i_dnc_weight_combine (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .size_n       (size_n_in),
    .beta         (beta_in),
    .dot_acc      (dot_acc),
    .energy_acc   (energy_acc),
    .row_done     (row_done),
    .ready        (ready),
    .c_out_enable (c_out_enable),
    .c_out        (c_out),
    .best_index   (best_index),
    .best_valid   (best_valid)
  );

endmodule

/* verif/dnc_read_content_checker.sv */
// DNC read content weighting protocol checker
// Bound to the top level, watches ready, score and best row strobes

`timescale 1ns/1ns

module dnc_read_content_checker (
  input logic clk,
  input logic rst,
  input logic ready,
  input logic c_out_enable,
  input logic best_valid
);

  //////////////////////////////
  // Strobe protocol
  //////////////////////////////

  // Score while ready is only legal for the last row of a run
  assert property (@(posedge clk) disable iff (rst)
    (c_out_enable && ready) |-> best_valid)
    else $error("score strobe while ready outside the last row");

  // Best row only comes with a score
  assert property (@(posedge clk) disable iff (rst)
    best_valid |-> c_out_enable)
    else $error("best_valid without c_out_enable");

  // Idle right out of reset
  assert property (@(posedge clk) $fell(rst) |-> ready)
    else $error("ready low after reset");

endmodule

bind dnc_read_content_weighting dnc_read_content_checker i_dnc_read_content_checker (
  .clk          (clk),
  .rst          (rst),
  .ready        (ready),
  .c_out_enable (c_out_enable),
  .best_valid   (best_valid)
);

/* verif/tb_dnc_read_content.sv */
// DNC read content weighting testbench
// Streams keys and memory rows, checks every score, its timing and the best row

`timescale 1ns/1ns

`include "dnc_params.svh"

module tb_dnc_read_content;

  logic clk, rst, start, ready, k_in_enable, m_in_j_enable, m_in_k_enable;
  logic c_out_enable, best_valid;
  dnc_ctrl_pkg::row_idx_t  size_n_in, best_index;
  dnc_ctrl_pkg::elem_idx_t size_w_in;
  dnc_elem_pkg::beta_t     beta_in;
  dnc_elem_pkg::elem_t     k_in, m_in;
  dnc_elem_pkg::score_t    c_out;

  integer seed = 32'h5495;
  int cycle = 0;
  int score_errors = 0;
  int index_errors = 0;
  int other_errors = 0;
  int scores_seen, run_rows;
  logic best_pulsed = 1'b0;
  string test_name = "reset";
  dnc_elem_pkg::elem_t    key_v [`DNC_MAX_W];
  dnc_elem_pkg::elem_t    mem_v [`DNC_MAX_N][`DNC_MAX_W];
  dnc_elem_pkg::score_t   got_score [`DNC_MAX_N];
  dnc_elem_pkg::score_t   exp_score_q [$];
  int                     exp_cycle_q [$];
  dnc_ctrl_pkg::row_idx_t exp_best;

  dnc_read_content_weighting i_dnc_read_content_weighting (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // beta * sum(2 k m - m m) of one row
  function automatic dnc_elem_pkg::score_t score_ref(int j, int w, dnc_elem_pkg::beta_t beta);
    int acc;
    acc = 0;
    for (int e = 0; e < w; e++)
      acc += 2 * int'(key_v[e]) * int'(mem_v[j][e]) - int'(mem_v[j][e]) * int'(mem_v[j][e]);
    return dnc_elem_pkg::score_t'(int'(beta) * acc);
  endfunction

  // First row holding the maximum
  function automatic dnc_ctrl_pkg::row_idx_t best_ref(int w, int n, dnc_elem_pkg::beta_t beta);
    dnc_elem_pkg::score_t   best;
    dnc_ctrl_pkg::row_idx_t idx;
    best = score_ref(0, w, beta);
    idx  = '0;
    for (int j = 1; j < n; j++) begin
      if (score_ref(j, w, beta) > best) begin
        best = score_ref(j, w, beta);
        idx  = dnc_ctrl_pkg::row_idx_t'(j);
      end
    end
    return idx;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic compare_score(string what, dnc_elem_pkg::score_t exp, dnc_elem_pkg::score_t act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
      score_errors++;
    end
  endtask

  task automatic compare_index(string what, dnc_ctrl_pkg::row_idx_t exp,
                               dnc_ctrl_pkg::row_idx_t act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
      index_errors++;
    end
  endtask

  task automatic compare_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
      other_errors++;
    end
  endtask

  // Score monitor, sampled mid cycle
  always @(negedge clk) begin
    if (!rst && c_out_enable) begin
      if (exp_score_q.size() == 0) begin
        $display("ERROR %s: score strobe with no row pending", test_name);
        other_errors++;
      end else begin
        compare_score("score", exp_score_q.pop_front(), c_out);
        got_score[scores_seen % `DNC_MAX_N] = c_out;
        if (exp_cycle_q.pop_front() != cycle) begin
          $display("ERROR %s: score %0d arrived at the wrong cycle", test_name, scores_seen);
          other_errors++;
        end
        scores_seen++;
      end
    end
    if (!rst && best_valid) begin
      best_pulsed = 1'b1;
      compare_flag("score with best_valid", 1'b1, c_out_enable);
      compare_flag("ready with best_valid", 1'b1, ready);
      compare_index("best index", exp_best, best_index);
      compare_index("scores at best_valid", dnc_ctrl_pkg::row_idx_t'(run_rows),
                    dnc_ctrl_pkg::row_idx_t'(scores_seen));
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic finish_sim();
    $display("errors: score %0d, index %0d, other %0d", score_errors, index_errors,
             other_errors);
    if (score_errors + index_errors + other_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic drive_cycle(logic st, logic ke, dnc_elem_pkg::elem_t kv, logic mj, logic mk,
                             dnc_elem_pkg::elem_t mv);
    @(posedge clk);
    #1;
    start         = st;
    k_in_enable   = ke;
    k_in          = kv;
    m_in_j_enable = mj;
    m_in_k_enable = mk;
    m_in          = mv;
  endtask

  task automatic idle_gap(bit gaps);
    if (gaps) repeat (rand_range(0, 3)) drive_cycle(0, 0, '0, 0, 0, '0);
  endtask

  task automatic wait_ready();
    int i;
    for (i = 0; i < 100 && !ready; i++) begin
      @(posedge clk);
      #1;
    end
    if (!ready) begin
      $display("ERROR %s: timeout waiting for ready", test_name);
      other_errors++;
      finish_sim();
    end
  endtask

  task automatic fill_random(int w, int n);
    for (int e = 0; e < w; e++) key_v[e] = dnc_elem_pkg::elem_t'($random(seed));
    for (int j = 0; j < n; j++)
      for (int e = 0; e < w; e++) mem_v[j][e] = dnc_elem_pkg::elem_t'($random(seed));
  endtask

  // One full run: start, key, rows, then wait for all scores
  task automatic run_case(int w, int n, dnc_elem_pkg::beta_t beta, bit gaps);
    int i;
    wait_ready();
    for (int j = 0; j < n; j++) exp_score_q.push_back(score_ref(j, w, beta));
    exp_best    = best_ref(w, n, beta);
    run_rows    = n;
    scores_seen = 0;
    best_pulsed = 1'b0;
    size_w_in   = dnc_ctrl_pkg::elem_idx_t'(w);
    size_n_in   = dnc_ctrl_pkg::row_idx_t'(n);
    beta_in     = beta;
    drive_cycle(1, 0, '0, 0, 0, '0);
    for (int e = 0; e < w; e++) begin
      idle_gap(gaps);
      drive_cycle(0, 1, key_v[e], 0, 0, '0);
    end
    for (int j = 0; j < n; j++) begin
      idle_gap(gaps);
      drive_cycle(0, 0, '0, 1, 0, '0);
      for (int e = 0; e < w; e++) begin
        idle_gap(gaps);
        drive_cycle(0, 0, '0, 0, 1, mem_v[j][e]);
        if (e == w - 1) exp_cycle_q.push_back(cycle + 2);
      end
    end
    drive_cycle(0, 0, '0, 0, 0, '0);
    // Ready comes back with the last score of the run
    for (i = 0; i < 400 && !ready; i++) begin
      @(posedge clk);
      #1;
    end
    if (!ready) begin
      $display("ERROR %s: timeout waiting for the scores of the run", test_name);
      other_errors++;
      finish_sim();
    end else begin
      // Monitor takes the last score on this falling edge
      @(negedge clk);
      #1;
      compare_index("score count", dnc_ctrl_pkg::row_idx_t'(n),
                    dnc_ctrl_pkg::row_idx_t'(scores_seen));
      compare_flag("best_valid pulse", 1'b1, best_pulsed);
      compare_index("best index held", exp_best, best_index);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int ksq;
    {start, k_in_enable, m_in_j_enable, m_in_k_enable} = '0;
    {k_in, m_in, beta_in, size_w_in, size_n_in} = '0;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    drive_cycle(0, 0, '0, 0, 0, '0);
    compare_flag("ready after reset", 1'b1, ready);
    compare_flag("no score after reset", 1'b0, c_out_enable);

    // Row equal to the key scores beta * |k|^2
    test_name = "exact_match";
    fill_random(4, 3);
    mem_v[1] = key_v;
    run_case(4, 3, 8'd37, 0);
    ksq = 0;
    for (int e = 0; e < 4; e++) ksq += int'(key_v[e]) * int'(key_v[e]);
    compare_score("beta*|k|^2", dnc_elem_pkg::score_t'(37 * ksq), got_score[1]);
    compare_index("exact row best", 7'd1, best_index);

    test_name = "random";
    for (int r = 0; r < 8; r++) begin
      int w, n;
      w = rand_range(1, `DNC_MAX_W);
      n = rand_range(1, `DNC_MAX_N);
      fill_random(w, n);
      run_case(w, n, dnc_elem_pkg::beta_t'($random(seed)), 0);
    end

    // Same data streamed back to back, then with idle cycles
    test_name = "strobe_gaps";
    fill_random(9, 12);
    run_case(9, 12, 8'd201, 0);
    run_case(9, 12, 8'd201, 1);

    // Maximum repeats at rows 1 and 4, lower tie at rows 2 and 3
    test_name = "ties";
    fill_random(3, 6);
    mem_v[1] = key_v;
    mem_v[4] = key_v;
    mem_v[3] = mem_v[2];
    run_case(3, 6, 8'd5, 1);
    compare_index("first max row", 7'd1, best_index);

    // Garbage strobes while idle
    test_name = "ignored_strobes";
    for (int i = 0; i < 10; i++)
      drive_cycle(0, i[0], dnc_elem_pkg::elem_t'($random(seed)), i % 3 == 0, !i[0],
                  dnc_elem_pkg::elem_t'($random(seed)));
    drive_cycle(0, 0, '0, 0, 0, '0);
    compare_flag("no score while idle", 1'b0, c_out_enable);
    fill_random(6, 5);
    run_case(6, 5, 8'd99, 0);

    repeat (3) @(posedge clk);
    finish_sim();
  end

endmodule

/* dnc_read_content.f */
+incdir+include
logic/dnc_elem_pkg.sv
logic/dnc_ctrl_pkg.sv
logic/dnc_key_similarity.sv
logic/dnc_row_energy.sv
logic/dnc_weight_combine.sv
logic/dnc_read_content_weighting.sv
verif/dnc_read_content_checker.sv
verif/tb_dnc_read_content.sv

/* Makefile */
# Verilator build and run of the DNC read content weighting testbench

TOP := tb_dnc_read_content

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		-f dnc_read_content.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
